/* verilog/emu_ctrl_pkg.sv */
package emu_ctrl_pkg;

    typedef logic [15:0] axil_addr_t;  // byte address
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'd0;
    localparam axil_resp_t RESP_SLVERR = 2'd2;

    // driven by the host
    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

    localparam axil_addr_t REG_CTRL        = 16'h000;  // bit0 run, bit1 clear
    localparam axil_addr_t REG_STEP        = 16'h004;
    localparam axil_addr_t REG_STATUS      = 16'h008;  // bit0 busy, bit1 overflow
    localparam axil_addr_t REG_CYCLE       = 16'h00C;
    localparam axil_addr_t REG_TRACE_COUNT = 16'h010;
    localparam axil_addr_t REG_TRACE_DATA  = 16'h014;  // read pops
    localparam axil_addr_t IMEM_BASE       = 16'h400;  // one word per instruction

endpackage

/* verilog/emu_cpu_pkg.sv */
package emu_cpu_pkg;

    typedef logic [15:0] cpu_data_t;
    typedef logic [2:0]  reg_addr_t;

    // op[15:12] rd[11:9] then rs[8:6] rt[5:3], or imm[7:0]
    typedef logic [15:0] instr_t;

    typedef logic [3:0]  opcode_t;

    localparam opcode_t OP_NOP = 4'd0;
    localparam opcode_t OP_LI  = 4'd1;
    localparam opcode_t OP_ADD = 4'd2;
    localparam opcode_t OP_SUB = 4'd3;
    localparam opcode_t OP_XOR = 4'd4;

    // waddr sits in the top bits so the bus word is {waddr, wdata}
    typedef struct packed {
        reg_addr_t waddr;
        cpu_data_t wdata;
    } rf_wr_t;

endpackage

/* verilog/axil_ctrl_bridge.sv */
`timescale 1ns/1ps

module axil_ctrl_bridge #(
    parameter int IMEM_DEPTH  = 64,
    parameter int TRACE_DEPTH = 16
) (
    input  logic                             emu_ref,
    input  logic                             rst,
    input  emu_ctrl_pkg::axil_req_t          ctrl_req,
    output emu_ctrl_pkg::axil_rsp_t          ctrl_rsp,
    input  logic                             busy,
    input  emu_ctrl_pkg::axil_data_t         cycle,
    input  emu_cpu_pkg::instr_t              imem_rdata,
    input  logic [$clog2(TRACE_DEPTH+1)-1:0] trace_count,
    input  emu_cpu_pkg::rf_wr_t              trace_head,
    input  logic                             overflow,
    output logic                             run,
    output logic                             step_wr,
    output emu_ctrl_pkg::axil_data_t         step_count,
    output logic                             clear,
    output logic                             imem_we,
    output logic [$clog2(IMEM_DEPTH)-1:0]    imem_addr,
    output emu_cpu_pkg::instr_t              imem_wdata,
    output logic                             trace_pop
);

    import emu_ctrl_pkg::*;
    import emu_cpu_pkg::*;

    localparam int IA = $clog2(IMEM_DEPTH);

    typedef enum logic [1:0] {IDLE, WRESP, RRESP} bus_state_t;

    bus_state_t state;
    logic       aw_rdy;
    logic       ar_rdy;
    logic       bvalid;
    axil_resp_t bresp;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       wr_acc;
    logic       rd_acc;
    logic       idle_free;
    logic       wr_hit;
    logic       rd_hit;
    logic       rd_pop;
    axil_data_t rd_word;

    function automatic logic in_imem(axil_addr_t a);
        axil_addr_t off;
        off = a - IMEM_BASE;
        return (a >= IMEM_BASE) && (off[1:0] == 2'b00) && ((off >> 2) < IMEM_DEPTH);
    endfunction

    function automatic logic [IA-1:0] imem_index(axil_addr_t a);
        axil_addr_t off;
        off = a - IMEM_BASE;
        return off[IA+1:2];
    endfunction

    assign wr_acc    = (state == IDLE) && aw_rdy;
    assign rd_acc    = (state == IDLE) && !aw_rdy && ar_rdy;
    assign idle_free = (state == IDLE) && !aw_rdy && !ar_rdy;

    assign wr_hit = (ctrl_req.awaddr inside {REG_CTRL, REG_STEP, REG_STATUS, REG_CYCLE,
                                             REG_TRACE_COUNT, REG_TRACE_DATA})
                    || in_imem(ctrl_req.awaddr);

    // read mux, sampled on the arready cycle
    always_comb begin
        rd_word = '0;
        rd_hit  = 1'b1;
        rd_pop  = 1'b0;
        case (ctrl_req.araddr)
            REG_CTRL:        rd_word[0] = run;
            REG_STEP:        rd_word = step_count;
            REG_STATUS:      rd_word[1:0] = {overflow, busy};
            REG_CYCLE:       rd_word = cycle;
            REG_TRACE_COUNT: rd_word = axil_data_t'(trace_count);
            REG_TRACE_DATA: begin
                if (trace_count != '0) begin  // empty buffer reads 0
                    rd_word = axil_data_t'(trace_head);
                    rd_pop  = 1'b1;
                end
            end
            default: begin
                if (in_imem(ctrl_req.araddr)) begin
                    rd_word = axil_data_t'(imem_rdata);  // imem_addr already points here
                end else begin
                    rd_hit = 1'b0;
                end
            end
        endcase
    end

    always_ff @(posedge emu_ref) begin
        if (rst) begin
            state      <= IDLE;
            aw_rdy     <= 1'b0;
            ar_rdy     <= 1'b0;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            run        <= 1'b0;
            step_wr    <= 1'b0;
            step_count <= '0;
            clear      <= 1'b0;
            imem_we    <= 1'b0;
            trace_pop  <= 1'b0;
        end else begin
            step_wr   <= 1'b0;
            clear     <= 1'b0;
            imem_we   <= 1'b0;
            trace_pop <= 1'b0;
            case (state)
                IDLE: begin
                    if (wr_acc) begin
                        aw_rdy <= 1'b0;
                        bvalid <= 1'b1;
                        state  <= WRESP;
                        case (ctrl_req.awaddr)
                            REG_CTRL: begin
                                run   <= ctrl_req.wdata[0];
                                clear <= ctrl_req.wdata[1];
                            end
                            REG_STEP: begin
                                step_count <= ctrl_req.wdata;
                                step_wr    <= 1'b1;
                            end
                            default: imem_we <= in_imem(ctrl_req.awaddr);
                        endcase
                    end else if (rd_acc) begin
                        ar_rdy    <= 1'b0;
                        rvalid    <= 1'b1;
                        trace_pop <= rd_pop;
                        state     <= RRESP;
                    end else if (ctrl_req.awvalid && ctrl_req.wvalid) begin
                        aw_rdy <= 1'b1;  // writes win over a pending read
                    end else if (ctrl_req.arvalid) begin
                        ar_rdy <= 1'b1;
                    end
                end
                WRESP: begin
                    if (ctrl_req.bready) begin
                        bvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end
                RRESP: begin
                    if (ctrl_req.rready) begin
                        rvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge emu_ref) begin
        if (idle_free) begin
            if (ctrl_req.awvalid && ctrl_req.wvalid) begin
                imem_addr <= imem_index(ctrl_req.awaddr);
            end else if (ctrl_req.arvalid) begin
                imem_addr <= imem_index(ctrl_req.araddr);
            end
        end
        if (wr_acc) begin
            imem_wdata <= instr_t'(ctrl_req.wdata);
            bresp      <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_acc) begin
            rdata <= rd_word;
            rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_comb begin
        ctrl_rsp.awready = aw_rdy;
        ctrl_rsp.wready  = aw_rdy;
        ctrl_rsp.bvalid  = bvalid;
        ctrl_rsp.bresp   = bresp;
        ctrl_rsp.arready = ar_rdy;
        ctrl_rsp.rvalid  = rvalid;
        ctrl_rsp.rdata   = rdata;
        ctrl_rsp.rresp   = rresp;
    end

endmodule

/* verilog/emu_clock_ctrl.sv */
`timescale 1ns/1ps

module emu_clock_ctrl (
    input  logic                     emu_ref,
    input  logic                     rst,
    input  logic                     run,
    input  logic                     step_wr,
    input  emu_ctrl_pkg::axil_data_t step_count,
    input  logic                     clear,
    output logic                     cpu_en,
    output logic                     busy,
    output emu_ctrl_pkg::axil_data_t cycle
);

    import emu_ctrl_pkg::*;

    axil_data_t steps_left;  // single-step cycles still to run

    assign cpu_en = run || (steps_left != '0);

    // step_wr covers the cycle before the counter is loaded
    assign busy = cpu_en || step_wr;

    always_ff @(posedge emu_ref) begin
        if (rst) begin
            steps_left <= '0;
        end else if (step_wr) begin
            steps_left <= step_count;
        end else if (steps_left != '0) begin
            steps_left <= steps_left - 1'b1;
        end
    end

    // emulated cycle count
    always_ff @(posedge emu_ref) begin
        if (rst || clear) begin
            cycle <= '0;
        end else if (cpu_en) begin
            cycle <= cycle + 1'b1;
        end
    end

endmodule

/* verilog/emu_cpu.sv */
`timescale 1ns/1ps

module emu_cpu #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          emu_ref,
    input  logic                          rst,
    input  logic                          clear,
    input  logic                          cpu_en,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
    input  emu_cpu_pkg::instr_t           imem_wdata,
    output emu_cpu_pkg::instr_t           imem_rdata,
    output logic                          rf_wen,
    output emu_cpu_pkg::rf_wr_t           rf_wr
);

    import emu_cpu_pkg::*;

    localparam int IA = $clog2(IMEM_DEPTH);

    instr_t        imem [IMEM_DEPTH];
    cpu_data_t     regs [8];
    logic [IA-1:0] pc;

    instr_t        instr;
    opcode_t       op;
    reg_addr_t     rd;
    reg_addr_t     rs;
    reg_addr_t     rt;
    cpu_data_t     op_a;
    cpu_data_t     op_b;
    cpu_data_t     result;
    logic          writes;

    // host side of the instruction memory
    always_ff @(posedge emu_ref) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign imem_rdata = imem[imem_addr];

    assign instr = imem[pc];
    assign op    = instr[15:12];
    assign rd    = instr[11:9];
    assign rs    = instr[8:6];
    assign rt    = instr[5:3];
    assign op_a  = regs[rs];
    assign op_b  = regs[rt];

    always_comb begin
        writes = 1'b1;
        case (op)
            OP_LI:   result = cpu_data_t'(instr[7:0]);  // zero-extended
            OP_ADD:  result = op_a + op_b;
            OP_SUB:  result = op_a - op_b;
            OP_XOR:  result = op_a ^ op_b;
            default: begin
                result = '0;
                writes = 1'b0;  // nop and unused opcodes
            end
        endcase
    end

    // one instruction per enabled cycle
    always_ff @(posedge emu_ref) begin
        if (rst || clear) begin
            pc     <= '0;
            regs   <= '{default: '0};
            rf_wen <= 1'b0;
        end else begin
            rf_wen <= cpu_en && writes;
            if (cpu_en) begin
                pc <= (pc == IMEM_DEPTH - 1) ? '0 : pc + 1'b1;
                if (writes) begin
                    regs[rd] <= result;
                end
            end
        end
    end

    // copy of the write for the trace, qualified by rf_wen
    always_ff @(posedge emu_ref) begin
        if (cpu_en && writes) begin
            rf_wr.waddr <= rd;
            rf_wr.wdata <= result;
        end
    end

endmodule

/* verilog/rf_trace_buf.sv */
`timescale 1ns/1ps

module rf_trace_buf #(
    parameter int TRACE_DEPTH = 16
) (
    input  logic                             emu_ref,
    input  logic                             rst,
    input  logic                             clear,
    input  logic                             rf_wen,
    input  emu_cpu_pkg::rf_wr_t              rf_wr,
    input  logic                             trace_pop,
    output logic [$clog2(TRACE_DEPTH+1)-1:0] trace_count,
    output emu_cpu_pkg::rf_wr_t              trace_head,
    output logic                             overflow
);

    import emu_cpu_pkg::*;

    localparam int PW = $clog2(TRACE_DEPTH);

    rf_wr_t        mem [TRACE_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic          full;
    logic          push;
    logic          pop;

    function automatic logic [PW-1:0] ptr_inc(logic [PW-1:0] p);
        return (p == TRACE_DEPTH - 1) ? '0 : p + 1'b1;
    endfunction

    assign full       = (trace_count == TRACE_DEPTH);
    assign push       = rf_wen && !full;  // drop when full, keep the oldest
    assign pop        = trace_pop && (trace_count != '0);
    assign trace_head = mem[rd_ptr];

    always_ff @(posedge emu_ref) begin
        if (push) begin
            mem[wr_ptr] <= rf_wr;
        end
    end

    always_ff @(posedge emu_ref) begin
        if (rst || clear) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            trace_count <= '0;
            overflow    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (push && !pop) begin
                trace_count <= trace_count + 1'b1;
            end else if (pop && !push) begin
                trace_count <= trace_count - 1'b1;
            end
            if (rf_wen && full) begin
                overflow <= 1'b1;  // sticky until clear
            end
        end
    end

endmodule

/* verilog/emu_system.sv */
`timescale 1ns/1ps

module emu_system #(
    parameter int IMEM_DEPTH  = 64,
    parameter int TRACE_DEPTH = 16
) (
    input  logic                    emu_ref,
    input  logic                    rst,
    input  emu_ctrl_pkg::axil_req_t ctrl_req,
    output emu_ctrl_pkg::axil_rsp_t ctrl_rsp
);

    import emu_ctrl_pkg::*;
    import emu_cpu_pkg::*;

    logic                             run;
    logic                             step_wr;
    axil_data_t                       step_count;
    logic                             clear;
    logic                             cpu_en;
    logic                             busy;
    axil_data_t                       cycle;
    logic                             imem_we;
    logic [$clog2(IMEM_DEPTH)-1:0]    imem_addr;
    instr_t                           imem_wdata;
    instr_t                           imem_rdata;
    logic                             rf_wen;
    rf_wr_t                           rf_wr;
    logic                             trace_pop;
    logic [$clog2(TRACE_DEPTH+1)-1:0] trace_count;
    rf_wr_t                           trace_head;
    logic                             overflow;

    axil_ctrl_bridge #(
        .IMEM_DEPTH  (IMEM_DEPTH),
        .TRACE_DEPTH (TRACE_DEPTH)
    ) u_bridge (
        .emu_ref     (emu_ref),
        .rst         (rst),
        .ctrl_req    (ctrl_req),
        .ctrl_rsp    (ctrl_rsp),
        .busy        (busy),
        .cycle       (cycle),
        .imem_rdata  (imem_rdata),
        .trace_count (trace_count),
        .trace_head  (trace_head),
        .overflow    (overflow),
        .run         (run),
        .step_wr     (step_wr),
        .step_count  (step_count),
        .clear       (clear),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .trace_pop   (trace_pop)
    );

    emu_clock_ctrl u_clock_ctrl (
        .emu_ref    (emu_ref),
        .rst        (rst),
        .run        (run),
        .step_wr    (step_wr),
        .step_count (step_count),
        .clear      (clear),
        .cpu_en     (cpu_en),
        .busy       (busy),
        .cycle      (cycle)
    );

    emu_cpu #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_cpu (
        .emu_ref    (emu_ref),
        .rst        (rst),
        .clear      (clear),
        .cpu_en     (cpu_en),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .imem_rdata (imem_rdata),
        .rf_wen     (rf_wen),
        .rf_wr      (rf_wr)
    );

    rf_trace_buf #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) u_trace (
        .emu_ref     (emu_ref),
        .rst         (rst),
        .clear       (clear),
        .rf_wen      (rf_wen),
        .rf_wr       (rf_wr),
        .trace_pop   (trace_pop),
        .trace_count (trace_count),
        .trace_head  (trace_head),
        .overflow    (overflow)
    );

endmodule

/* verif/emu_system_tb.sv */
`timescale 1ns/1ps

module emu_system_tb;

    import emu_ctrl_pkg::*;
    import emu_cpu_pkg::*;

    localparam int IMEM_DEPTH  = 64;
    localparam int TRACE_DEPTH = 16;
    localparam int WAIT_LIMIT  = 64;   // cycles per handshake wait
    localparam int POLL_LIMIT  = 200;  // register polls
    localparam int NUM_TESTS   = 6;

    logic      emu_ref;
    logic      rst;
    axil_req_t ctrl_req;
    axil_rsp_t ctrl_rsp;

    // name, program length, step count, overflow expected
    string test_name  [NUM_TESTS] = '{"single_step", "short_prog", "full_depth",
                                      "overflow", "imem_wrap", "after_clear"};
    int    test_len   [NUM_TESTS] = '{1, 6, 16, 20, 8, 10};
    int    test_steps [NUM_TESTS] = '{1, 5, 16, 48, 70, 12};
    bit    test_ovf   [NUM_TESTS] = '{0, 0, 0, 1, 1, 0};

    instr_t      model_imem [IMEM_DEPTH];
    cpu_data_t   model_regs [8];
    int          model_pc;
    bit          model_ovf;
    rf_wr_t      exp_trace [$];  // oldest first, capped at TRACE_DEPTH
    int unsigned lcg_state;

    emu_system #(
        .IMEM_DEPTH  (IMEM_DEPTH),
        .TRACE_DEPTH (TRACE_DEPTH)
    ) UUT (
        .emu_ref  (emu_ref),
        .rst      (rst),
        .ctrl_req (ctrl_req),
        .ctrl_rsp (ctrl_rsp)
    );

    always #2 emu_ref = ~emu_ref;

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s", what);
        abort_run();
    endtask

    task automatic next_cycle();
        @(posedge emu_ref);
        #0.5;
    endtask

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // about two of three picks write a register
    function automatic instr_t random_instr();
        logic [15:0] sel;
        logic [15:0] low;
        opcode_t     op;
        sel = lcg_next();
        low = lcg_next();
        case (sel % 16'd6)
            0: op = OP_NOP;
            1: op = OP_LI;
            2: op = OP_ADD;
            3: op = OP_SUB;
            4: op = OP_XOR;
            default: op = 4'hB;  // unused opcode
        endcase
        return {op, low[11:0]};
    endfunction

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output axil_resp_t resp);
        int n;
        ctrl_req.awaddr  = addr;
        ctrl_req.wdata   = data;
        ctrl_req.awvalid = 1'b1;
        ctrl_req.wvalid  = 1'b1;
        ctrl_req.bready  = 1'b1;
        n = 0;
        while (!ctrl_rsp.awready) begin
            next_cycle();
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout("awready");
            end
        end
        check_value("wready with awready", 1, 32'(ctrl_rsp.wready));
        next_cycle();  // accepted on this edge
        ctrl_req.awvalid = 1'b0;
        ctrl_req.wvalid  = 1'b0;
        n = 0;
        while (!ctrl_rsp.bvalid) begin
            next_cycle();
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout("bvalid");
            end
        end
        resp = ctrl_rsp.bresp;
        next_cycle();
        ctrl_req.bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        int n;
        ctrl_req.araddr  = addr;
        ctrl_req.arvalid = 1'b1;
        ctrl_req.rready  = 1'b1;
        n = 0;
        while (!ctrl_rsp.arready) begin
            next_cycle();
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout("arready");
            end
        end
        next_cycle();
        ctrl_req.arvalid = 1'b0;
        n = 0;
        while (!ctrl_rsp.rvalid) begin
            next_cycle();
            n++;
            if (n > WAIT_LIMIT) begin
                report_timeout("rvalid");
            end
        end
        data = ctrl_rsp.rdata;
        resp = ctrl_rsp.rresp;
        next_cycle();
        ctrl_req.rready = 1'b0;
    endtask

    task automatic reg_write(input axil_addr_t addr, input axil_data_t data);
        axil_resp_t resp;
        axil_write(addr, data, resp);
        check_value($sformatf("bresp at 0x%04h", addr), 32'(RESP_OKAY), 32'(resp));
    endtask

    task automatic reg_read(input axil_addr_t addr, output axil_data_t data);
        axil_resp_t resp;
        axil_read(addr, data, resp);
        check_value($sformatf("rresp at 0x%04h", addr), 32'(RESP_OKAY), 32'(resp));
    endtask

    task automatic wait_idle();
        axil_data_t status;
        int         polls;
        polls = 0;
        reg_read(REG_STATUS, status);
        while (status[0]) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                report_timeout("busy to fall");
            end
            reg_read(REG_STATUS, status);
        end
    endtask

    task automatic model_clear();
        int i;
        for (i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        model_pc  = 0;
        model_ovf = 1'b0;
        exp_trace.delete();
    endtask

    // ISA reference, one instruction per emulated cycle
    task automatic model_step(input int cycles);
        int        i;
        instr_t    ins;
        cpu_data_t a;
        cpu_data_t b;
        cpu_data_t val;
        bit        wr;
        rf_wr_t    ent;
        for (i = 0; i < cycles; i++) begin
            ins = model_imem[model_pc];
            a   = model_regs[ins[8:6]];
            b   = model_regs[ins[5:3]];
            wr  = 1'b1;
            case (ins[15:12])
                OP_LI:   val = {8'h00, ins[7:0]};
                OP_ADD:  val = a + b;
                OP_SUB:  val = a - b;
                OP_XOR:  val = a ^ b;
                default: begin
                    val = '0;
                    wr  = 1'b0;
                end
            endcase
            if (wr) begin
                model_regs[ins[11:9]] = val;
                ent.waddr = ins[11:9];
                ent.wdata = val;
                if (exp_trace.size() < TRACE_DEPTH) begin
                    exp_trace.push_back(ent);
                end else begin
                    model_ovf = 1'b1;  // newest write is lost
                end
            end
            model_pc = (model_pc + 1) % IMEM_DEPTH;
        end
    endtask

    task automatic load_program(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            model_imem[i] = random_instr();
            reg_write(IMEM_BASE + axil_addr_t'(4 * i), axil_data_t'(model_imem[i]));
        end
    endtask

    task automatic clear_system(input string name);
        axil_data_t d;
        reg_write(REG_CTRL, 32'h2);
        model_clear();
        reg_read(REG_STATUS, d);
        check_value({name, " status after clear"}, 0, d);
        reg_read(REG_CYCLE, d);
        check_value({name, " cycle after clear"}, 0, d);
        reg_read(REG_TRACE_COUNT, d);
        check_value({name, " trace count after clear"}, 0, d);
    endtask

    task automatic drain_trace(input string name);
        axil_data_t d;
        int         n;
        int         i;
        n = exp_trace.size();
        for (i = 0; i < n; i++) begin
            reg_read(REG_TRACE_COUNT, d);
            check_value($sformatf("%s count before pop %0d", name, i), n - i, d);
            reg_read(REG_TRACE_DATA, d);
            check_value($sformatf("%s trace entry %0d", name, i), 32'(exp_trace[i]), d);
        end
        reg_read(REG_TRACE_COUNT, d);
        check_value({name, " count after drain"}, 0, d);
        reg_read(REG_TRACE_DATA, d);
        check_value({name, " read of empty trace"}, 0, d);
    endtask

    task automatic finish_run(input string name, input int cycles, input bit exp_ovf);
        axil_data_t d;
        wait_idle();
        reg_read(REG_CYCLE, d);
        check_value({name, " cycle"}, cycles, d);
        reg_read(REG_STATUS, d);
        check_value({name, " status"}, {30'b0, model_ovf, 1'b0}, d);
        check_value({name, " overflow flag"}, 32'(exp_ovf), 32'(d[1]));
        drain_trace(name);
    endtask

    initial begin
        axil_data_t d;
        axil_resp_t resp;
        axil_data_t saved [4];
        axil_addr_t bad_addr [4];
        int         t;
        int         polls;
        emu_ref   = 1'b0;
        rst       = 1'b1;
        ctrl_req  = '0;
        lcg_state = 53;
        bad_addr  = '{16'h0018, 16'h0030, 16'h0402, 16'h0500};
        repeat (5) @(posedge emu_ref);
        #0.5;
        rst = 1'b0;

        check_value("awready after reset", 0, 32'(ctrl_rsp.awready));
        check_value("wready after reset", 0, 32'(ctrl_rsp.wready));
        check_value("arready after reset", 0, 32'(ctrl_rsp.arready));
        check_value("bvalid after reset", 0, 32'(ctrl_rsp.bvalid));
        check_value("rvalid after reset", 0, 32'(ctrl_rsp.rvalid));
        reg_read(REG_STATUS, d);
        check_value("status after reset", 0, d);
        reg_read(REG_CYCLE, d);
        check_value("cycle after reset", 0, d);
        reg_read(REG_TRACE_COUNT, d);
        check_value("trace count after reset", 0, d);

        // fill every imem word so the model knows what a wrapped pc fetches
        load_program(IMEM_DEPTH);
        for (t = 0; t < IMEM_DEPTH; t++) begin
            reg_read(IMEM_BASE + axil_addr_t'(4 * t), d);
            check_value($sformatf("imem readback %0d", t), 32'(model_imem[t]), d);
        end

        for (t = 0; t < NUM_TESTS; t++) begin
            clear_system(test_name[t]);
            load_program(test_len[t]);
            reg_write(REG_STEP, test_steps[t]);
            model_step(test_steps[t]);
            finish_run(test_name[t], test_steps[t], test_ovf[t]);
        end

        clear_system("free_run");
        load_program(10);
        reg_write(REG_CTRL, 32'h1);
        polls = 0;
        reg_read(REG_CYCLE, d);
        while (d < 6) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                report_timeout("the free run to count cycles");
            end
            reg_read(REG_CYCLE, d);
        end
        reg_write(REG_CTRL, 32'h0);
        reg_read(REG_CYCLE, d);  // stopped, final count
        model_step(int'(d));
        finish_run("free_run", int'(d), model_ovf);

        reg_read(REG_CYCLE, saved[0]);
        reg_read(REG_TRACE_COUNT, saved[1]);
        reg_read(REG_STATUS, saved[2]);
        reg_read(IMEM_BASE, saved[3]);
        check_value("imem word 0 before bad access", 32'(model_imem[0]), saved[3]);
        for (t = 0; t < 4; t++) begin
            axil_write(bad_addr[t], 32'hFFFF_FFFF, resp);
            check_value($sformatf("bresp unmapped 0x%04h", bad_addr[t]),
                        32'(RESP_SLVERR), 32'(resp));
            axil_read(bad_addr[t], d, resp);
            check_value($sformatf("rresp unmapped 0x%04h", bad_addr[t]),
                        32'(RESP_SLVERR), 32'(resp));
            check_value($sformatf("rdata unmapped 0x%04h", bad_addr[t]), 0, d);
        end
        reg_read(REG_CYCLE, d);
        check_value("cycle after bad access", saved[0], d);
        reg_read(REG_TRACE_COUNT, d);
        check_value("trace count after bad access", saved[1], d);
        reg_read(REG_STATUS, d);
        check_value("status after bad access", saved[2], d);
        reg_read(IMEM_BASE, d);
        check_value("imem word 0 after bad access", saved[3], d);

        $display("TEST OK");
        $finish;
    end

endmodule

/* emu_system.f */
verilog/emu_ctrl_pkg.sv
verilog/emu_cpu_pkg.sv
verilog/axil_ctrl_bridge.sv
verilog/emu_clock_ctrl.sv
verilog/emu_cpu.sv
verilog/rf_trace_buf.sv
verilog/emu_system.sv
verif/emu_system_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=emu_system_sim
LOG=sim.log

verilator --binary -j 0 -Wno-fatal --top-module emu_system_tb \
    -f emu_system.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
echo "simulation passed"
exit 0
